/* logic/buffer_bank.sv */
`default_nettype none
`timescale 1ns/1ns

module buffer_bank #(
	parameter int FRAME_WORDS = frame_pkg::DEFAULT_FRAME_WORDS,
	localparam int ADDR_WIDTH = $clog2(FRAME_WORDS)
) (
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  wr_en,
	input  buffer_pkg::buf_idx_t  wr_bank,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  frame_pkg::pixel_t     wr_data,
	input  buffer_pkg::buf_idx_t  rd_bank,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output frame_pkg::pixel_t     rd_data
);

	logic [buffer_pkg::NUM_BUFFERS-1:0] bank_wr_en;
	frame_pkg::pixel_t                  ram_q [buffer_pkg::NUM_BUFFERS];
	buffer_pkg::buf_idx_t               rd_bank_q;
	logic                               rd_live;

	for (genvar g = 0; g < buffer_pkg::NUM_BUFFERS; g++) begin : g_ram
		assign bank_wr_en[g] = wr_en && (wr_bank == buffer_pkg::buf_idx_t'(g));

		line_ram #(
			.FRAME_WORDS(FRAME_WORDS)
		) u_line_ram (
			.clk    (clk),
			.wr_en  (bank_wr_en[g]),
			.wr_addr(wr_addr),
			.wr_data(wr_data),
			.rd_addr(rd_addr),
			.rd_data(ram_q[g])
		);
	end

	// Bank select follows the RAM read by one cycle
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rd_bank_q <= '0;
			rd_live   <= 1'b0;
		end else begin
			rd_bank_q <= rd_bank;
			rd_live   <= 1'b1;
		end
	end

	// Output stays zero until the first read out of reset has completed
	assign rd_data = rd_live ? ram_q[rd_bank_q] : '0;

	// The bank on the read output never takes a write in that cycle
	assert property (@(posedge clk) disable iff (!nrst)
		wr_en |-> (wr_bank != rd_bank_q));

endmodule

`default_nettype wire

/* logic/buffer_pkg.sv */
`default_nettype none

package buffer_pkg;

	localparam int NUM_BUFFERS = 3;

	typedef logic [1:0] buf_idx_t;

	// Current role of each of the three buffers
	typedef struct packed {
		buf_idx_t write_idx;
		buf_idx_t read_idx;
		buf_idx_t free_idx;
	} buf_sel_t;

	localparam buf_sel_t RESET_SEL = '{
		write_idx: 2'd0,
		read_idx:  2'd1,
		free_idx:  2'd2
	};

endpackage

`default_nettype wire

/* logic/buffer_rotator.sv */
`default_nettype none
`timescale 1ns/1ns

module buffer_rotator (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 frame_written,
	input  logic                 read_done,
	output buffer_pkg::buf_sel_t sel
);

	logic                 read_done_d1;
	logic                 read_done_d2;
	logic                 read_edge;
	buffer_pkg::buf_sel_t sel_next;

	// Rising edge of read_done, one cycle after it is sampled
	assign read_edge = read_done_d1 && !read_done_d2;

	always_comb begin
		sel_next = sel;
		if (read_edge && frame_written) begin
			// Free buffer is stale here, so reader takes the fresh frame directly
			sel_next.write_idx = sel.read_idx;
			sel_next.read_idx  = sel.write_idx;
		end else if (read_edge) begin
			sel_next.read_idx = sel.free_idx;
			sel_next.free_idx = sel.read_idx;
		end else if (frame_written) begin
			sel_next.write_idx = sel.free_idx;
			sel_next.free_idx  = sel.write_idx;
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			read_done_d1 <= 1'b0;
			read_done_d2 <= 1'b0;
			sel          <= buffer_pkg::RESET_SEL;
		end else begin
			read_done_d1 <= read_done;
			read_done_d2 <= read_done_d1;
			sel          <= sel_next;
		end
	end

	// Roles stay a permutation of the three buffers across every swap
	assert property (@(posedge clk) disable iff (!nrst)
		(sel.write_idx != sel.read_idx) &&
		(sel.write_idx != sel.free_idx) &&
		(sel.read_idx != sel.free_idx));

	assert property (@(posedge clk) disable iff (!nrst)
		(sel.write_idx < buffer_pkg::NUM_BUFFERS) &&
		(sel.read_idx < buffer_pkg::NUM_BUFFERS) &&
		(sel.free_idx < buffer_pkg::NUM_BUFFERS));

endmodule

`default_nettype wire

/* logic/frame_pkg.sv */
`default_nettype none

package frame_pkg;

	// Pixel format of the incoming video stream
	localparam int PIXEL_WIDTH = 24;
	localparam int DEFAULT_FRAME_WORDS = 128;

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;

	// One pixel strobe, no back-pressure
	typedef struct packed {
		logic   valid;
		pixel_t data;
	} pixel_wr_t;

endpackage

`default_nettype wire

/* logic/line_ram.sv */
`default_nettype none
`timescale 1ns/1ns

module line_ram #(
	parameter int FRAME_WORDS = frame_pkg::DEFAULT_FRAME_WORDS,
	localparam int ADDR_WIDTH = $clog2(FRAME_WORDS)
) (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  frame_pkg::pixel_t     wr_data,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output frame_pkg::pixel_t     rd_data
);

	frame_pkg::pixel_t mem [FRAME_WORDS];

	// Simple dual port, read data registered like a block RAM output
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* logic/triple_buffer.sv */
`default_nettype none
`timescale 1ns/1ns

module triple_buffer #(
	parameter int FRAME_WORDS = frame_pkg::DEFAULT_FRAME_WORDS,
	localparam int ADDR_WIDTH = $clog2(FRAME_WORDS)
) (
	input  logic                  clk,
	input  logic                  nrst,
	input  frame_pkg::pixel_wr_t  wr,
	input  logic [ADDR_WIDTH-1:0] read_addr,
	input  logic                  read_done,
	output frame_pkg::pixel_t     read_data,
	output buffer_pkg::buf_sel_t  sel
);

	logic                  ram_wr_en;
	buffer_pkg::buf_idx_t  ram_wr_bank;
	logic [ADDR_WIDTH-1:0] ram_wr_addr;
	frame_pkg::pixel_t     ram_wr_data;
	logic                  frame_written;

	write_port #(
		.FRAME_WORDS(FRAME_WORDS)
	) u_write_port (
		.clk          (clk),
		.nrst         (nrst),
		.wr           (wr),
		.write_idx    (sel.write_idx),
		.ram_wr_en    (ram_wr_en),
		.ram_wr_bank  (ram_wr_bank),
		.ram_wr_addr  (ram_wr_addr),
		.ram_wr_data  (ram_wr_data),
		.frame_written(frame_written)
	);

	buffer_rotator u_buffer_rotator (
		.clk          (clk),
		.nrst         (nrst),
		.frame_written(frame_written),
		.read_done    (read_done),
		.sel          (sel)
	);

	buffer_bank #(
		.FRAME_WORDS(FRAME_WORDS)
	) u_buffer_bank (
		.clk    (clk),
		.nrst   (nrst),
		.wr_en  (ram_wr_en),
		.wr_bank(ram_wr_bank),
		.wr_addr(ram_wr_addr),
		.wr_data(ram_wr_data),
		.rd_bank(sel.read_idx),
		.rd_addr(read_addr),
		.rd_data(read_data)
	);

endmodule

`default_nettype wire

/* logic/write_port.sv */
`default_nettype none
`timescale 1ns/1ns

module write_port #(
	parameter int FRAME_WORDS = frame_pkg::DEFAULT_FRAME_WORDS,
	localparam int ADDR_WIDTH = $clog2(FRAME_WORDS)
) (
	input  logic                  clk,
	input  logic                  nrst,
	input  frame_pkg::pixel_wr_t  wr,
	input  buffer_pkg::buf_idx_t  write_idx,
	output logic                  ram_wr_en,
	output buffer_pkg::buf_idx_t  ram_wr_bank,
	output logic [ADDR_WIDTH-1:0] ram_wr_addr,
	output frame_pkg::pixel_t     ram_wr_data,
	output logic                  frame_written
);

	localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(FRAME_WORDS - 1);

	logic [ADDR_WIDTH-1:0] wr_count;

	// High while the last pixel of the frame is on the input
	assign frame_written = wr.valid && (wr_count == LAST_ADDR);

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			wr_count  <= '0;
			ram_wr_en <= 1'b0;
		end else begin
			ram_wr_en <= wr.valid;
			if (wr.valid) begin
				// Wrap so the next pixel starts the new buffer at 0
				wr_count <= frame_written ? '0 : wr_count + ADDR_WIDTH'(1);
			end
		end
	end

	// Beat payload, bank taken from the write role at acceptance
	always_ff @(posedge clk) begin
		if (wr.valid) begin
			ram_wr_bank <= write_idx;
			ram_wr_addr <= wr_count;
			ram_wr_data <= wr.data;
		end
	end

	assert property (@(posedge clk) disable iff (!nrst)
		wr_count < FRAME_WORDS);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the triple_buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim_run.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module triple_buffer_tb -Mdir obj_dir -f triple_buffer.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtriple_buffer_tb > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi

if grep -q "Simulation failed" "$log"; then
	exit 1
fi
exit 0

/* sim/tb_clock.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic nrst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release reset on a falling edge, away from the sampling edge
	initial begin
		nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/triple_buffer_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module triple_buffer_tb;

	localparam int FRAME_WORDS = 128;
	localparam int ADDR_WIDTH = $clog2(FRAME_WORDS);
	localparam int SWAP_AT = 64;

	logic                  clk;
	logic                  nrst;
	frame_pkg::pixel_wr_t  wr;
	logic [ADDR_WIDTH-1:0] read_addr;
	logic                  read_done;
	frame_pkg::pixel_t     read_data;
	buffer_pkg::buf_sel_t  sel;

	// Reference model of buffer contents and roles
	frame_pkg::pixel_t     model_mem [3][FRAME_WORDS] = '{default: '0};
	buffer_pkg::buf_sel_t  model_sel = '{write_idx: 2'd0, read_idx: 2'd1, free_idx: 2'd2};
	logic [31:0]           rng_state = 32'h7eea_3a42;
	byte                   cmd_q [$];
	logic [31:0]           arg_q [$];
	int                    fd;
	int                    checks = 0;
	int                    errors = 0;
	int                    cycle_count = 0;
	int                    cycle_limit = 200;

	tb_clock u_tb_clock (
		.clk (clk),
		.nrst(nrst)
	);

	triple_buffer #(
		.FRAME_WORDS(FRAME_WORDS)
	) u_triple_buffer (
		.clk      (clk),
		.nrst     (nrst),
		.wr       (wr),
		.read_addr(read_addr),
		.read_done(read_done),
		.read_data(read_data),
		.sel      (sel)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED %s: actual 0x%h expected 0x%h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic report_and_finish();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			wr = '0;
			read_done = 1'b0;
		end
	endtask

	task automatic swap_read_free();
		buffer_pkg::buf_idx_t tmp;
		tmp = model_sel.read_idx;
		model_sel.read_idx = model_sel.free_idx;
		model_sel.free_idx = tmp;
	endtask

	task automatic write_frame(input logic [31:0] base, input bit read_too);
		buffer_pkg::buf_idx_t tmp;
		for (int i = 0; i < FRAME_WORDS; i++) begin
			if (i > 0) begin
				rng_state = lcg_step(rng_state);
				idle_cycles(int'(rng_state[17:16]));
			end
			if (read_too && i == FRAME_WORDS - 1) begin
				// Edge detector adds a cycle, so read_done rises one cycle ahead
				@(negedge clk);
				wr = '0;
				read_done = 1'b1;
			end
			@(negedge clk);
			wr.valid = 1'b1;
			wr.data = frame_pkg::pixel_t'(base + i);
			model_mem[model_sel.write_idx][i] = frame_pkg::pixel_t'(base + i);
		end
		tmp = model_sel.write_idx;
		if (read_too) begin
			// Free buffer is out of date, reader and writer trade
			model_sel.write_idx = model_sel.read_idx;
			model_sel.read_idx = tmp;
		end else begin
			model_sel.write_idx = model_sel.free_idx;
			model_sel.free_idx = tmp;
		end
	endtask

	task automatic read_frame(input bit pulse_mid);
		frame_pkg::pixel_t expected;
		idle_cycles(2);
		for (int i = 0; i <= FRAME_WORDS; i++) begin
			@(negedge clk);
			if (i > 0) begin
				check_value($sformatf("read_data[%0d]", i - 1), 32'(read_data), 32'(expected));
			end
			if (pulse_mid && i == SWAP_AT) begin
				read_done = 1'b1;
			end else if (pulse_mid && i == SWAP_AT + 1) begin
				read_done = 1'b0;
			end else if (pulse_mid && i == SWAP_AT + 2) begin
				// First address sampled after sel has moved
				swap_read_free();
			end
			if (i < FRAME_WORDS) begin
				read_addr = ADDR_WIDTH'(i);
				expected = model_mem[model_sel.read_idx][i];
			end
		end
	endtask

	task automatic next_command(output int c);
		c = $fgetc(fd);
		while (c == 32 || c == 9 || c == 10 || c == 13 || c == "#") begin
			if (c == "#") begin
				while (c != 10 && c != -1) begin
					c = $fgetc(fd);
				end
			end
			c = $fgetc(fd);
		end
	endtask

	task automatic load_tests(output bit ok);
		int c;
		int n;
		int w;
		int r;
		int f;
		logic [31:0] base;
		ok = 1'b0;
		fd = $fopen("sim/triple_buffer_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file sim/triple_buffer_tests.txt");
			errors++;
		end else begin
			next_command(c);
			while (c != -1) begin
				n = 0;
				case (c)
					"F", "B": begin
						n = ($fscanf(fd, "%h", base) == 1) ? 1 : 0;
						arg_q.push_back(base);
					end
					"S": begin
						n = ($fscanf(fd, "%d %d %d", w, r, f) == 3) ? 1 : 0;
						arg_q.push_back(32'({w[1:0], r[1:0], f[1:0]}));
					end
					"D", "R", "X": begin
						n = 1;
						arg_q.push_back('0);
					end
					default: n = 0;
				endcase
				if (n == 1) begin
					cmd_q.push_back(byte'(c));
				end else begin
					$display("Bad or unknown command in the test file after entry %0d", cmd_q.size());
					errors++;
				end
				next_command(c);
			end
			$fclose(fd);
			ok = (errors == 0);
		end
	endtask

	// Watchdog on the total cycle budget of the test list
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: tests did not finish within %0d cycles", cycle_limit);
			errors++;
			report_and_finish();
		end
	end

	initial begin
		bit loaded;
		wr = '0;
		read_addr = '0;
		read_done = 1'b0;
		load_tests(loaded);
		if (!loaded) begin
			report_and_finish();
		end else begin
			cycle_limit += cmd_q.size() * FRAME_WORDS * 4;
			@(posedge nrst);
			for (int i = 0; i < cmd_q.size(); i++) begin
				case (cmd_q[i])
					"F": write_frame(arg_q[i], 1'b0);
					"B": write_frame(arg_q[i], 1'b1);
					"D": begin
						idle_cycles(2);
						@(negedge clk);
						read_done = 1'b1;
						idle_cycles(3);
						swap_read_free();
					end
					"R": read_frame(1'b0);
					"X": read_frame(1'b1);
					"S": begin
						idle_cycles(2);
						check_value("sel.write_idx", 32'(sel.write_idx), 32'(arg_q[i][5:4]));
						check_value("sel.read_idx", 32'(sel.read_idx), 32'(arg_q[i][3:2]));
						check_value("sel.free_idx", 32'(sel.free_idx), 32'(arg_q[i][1:0]));
					end
				endcase
			end
			idle_cycles(2);
			report_and_finish();
		end
	end

endmodule

`default_nettype wire

/* sim/triple_buffer_tests.txt */
# F/B base (hex): write frame, pixel i = base+i, B also raises read_done on the last pixel
# D: read_done pulse, R: read all, X: read all across a read_done pulse, S: write read free
S 0 1 2
R
F 100000
S 2 1 0
D
S 2 0 1
R
D
S 2 1 0
R
B 200000
S 1 2 0
R
F 300000
F 400000
S 1 2 0
D
S 1 0 2
R
X
S 1 2 0
R
F 500000
F 600000
F 700000
D
S 0 1 2
R

/* triple_buffer.f */
logic/frame_pkg.sv
logic/buffer_pkg.sv
logic/line_ram.sv
logic/buffer_bank.sv
logic/write_port.sv
logic/buffer_rotator.sv
logic/triple_buffer.sv
sim/tb_clock.sv
sim/triple_buffer_tb.sv
